// File: include/glb_cfg.svh
// Global buffer tile configuration macros
// Data and address widths, tile count, config field widths
`ifndef GLB_CFG_SVH
`define GLB_CFG_SVH

// Word width on the bank and on both streams
`define GLB_DATA_WIDTH 16

// Bank word address, 256 words
`define GLB_ADDR_WIDTH 8

// Tiles on the interrupt chain
`define GLB_NUM_TILES 4

// Config address fields
`define GLB_TILE_ID_WIDTH 2
`define GLB_REG_SEL_WIDTH 3
`define GLB_CFG_ADDR_WIDTH (`GLB_TILE_ID_WIDTH + `GLB_REG_SEL_WIDTH)

`endif

// File: logic/glb_pkg.sv
// Global buffer package
// DMA state, DMA opcode and config register index types
`include "glb_cfg.svh"

package glb_pkg;

    // DMA controller states
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        STORE = 3'd1,
        LOAD  = 3'd2,
        DRAIN = 3'd3,
        DONE  = 3'd4
    } dma_state_t;

    // DMA opcodes as written to the control register
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_STORE = 2'd1,
        OP_LOAD  = 2'd2
    } dma_op_t;

    // Register select field of the config address
    typedef enum logic [`GLB_REG_SEL_WIDTH-1:0] {
        REG_ST_ADDR = 3'd0,
        REG_ST_NUM  = 3'd1,
        REG_LD_ADDR = 3'd2,
        REG_LD_NUM  = 3'd3,
        REG_CTRL    = 3'd4,
        REG_STATUS  = 3'd5
    } cfg_reg_t;

endpackage

// File: logic/glb_addr_counter.sv
// DMA region address and word counter
// Flags the final word of the region
`include "glb_cfg.svh"

module glb_addr_counter (
    input  logic                        clk,
    input  logic                        clk_en,
    input  logic                        reset,
    input  logic                        load,
    input  logic                        step,
    input  logic [`GLB_ADDR_WIDTH-1:0]  start_addr,
    input  logic [`GLB_ADDR_WIDTH-1:0]  num_words,
    output logic [`GLB_ADDR_WIDTH-1:0]  addr,
    output logic                        last
);

    // One extra bit so a full bank of 256 fits
    logic [`GLB_ADDR_WIDTH:0] remain;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            addr   <= '0;
            remain <= '0;
        end else if (clk_en) begin
            if (load) begin
                addr   <= start_addr;
                // Zero length means the whole bank
                remain <= (num_words == '0) ? {1'b1, {`GLB_ADDR_WIDTH{1'b0}}}
                                            : {1'b0, num_words};
            end else if (step) begin
                // Address wraps past the top word
                addr   <= addr + 1'b1;
                remain <= remain - 1'b1;
            end
        end
    end

    assign last = (remain == {{`GLB_ADDR_WIDTH{1'b0}}, 1'b1});

    a_no_step_on_load: assert property (
        @(posedge clk) disable iff (reset) !(load && step));

endmodule

// File: logic/glb_cfg_regs.sv
// Config bus decoder and DMA setup registers
// Launches a store or load DMA from the control register
`include "glb_cfg.svh"

module glb_cfg_regs import glb_pkg::*; (
    input  logic                            clk,
    input  logic                            clk_en,
    input  logic                            reset,
    input  logic [`GLB_TILE_ID_WIDTH-1:0]   glb_tile_id,
    input  logic                            cfg_wr_en,
    input  logic                            cfg_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]      cfg_wr_data,
    input  logic                            dma_busy,
    output logic [`GLB_DATA_WIDTH-1:0]      cfg_rd_data,
    output logic                            cfg_rd_valid,
    output logic [`GLB_ADDR_WIDTH-1:0]      start_addr,
    output logic [`GLB_ADDR_WIDTH-1:0]      num_words,
    output logic                            dma_start,
    output dma_op_t                         dma_op
);

    localparam int PAD = `GLB_DATA_WIDTH - `GLB_ADDR_WIDTH;

    logic                          tile_hit;
    logic                          wr_hit;
    logic                          rd_hit;
    logic                          launch;
    cfg_reg_t                      reg_sel;
    dma_op_t                       wr_op;
    logic [`GLB_DATA_WIDTH-1:0]    rd_mux;
    logic [`GLB_ADDR_WIDTH-1:0]    st_addr;
    logic [`GLB_ADDR_WIDTH-1:0]    st_num;
    logic [`GLB_ADDR_WIDTH-1:0]    ld_addr;
    logic [`GLB_ADDR_WIDTH-1:0]    ld_num;

    // Tile select sits above the register select
    assign tile_hit = cfg_addr[`GLB_CFG_ADDR_WIDTH-1 -: `GLB_TILE_ID_WIDTH] == glb_tile_id;
    assign reg_sel  = cfg_reg_t'(cfg_addr[`GLB_REG_SEL_WIDTH-1:0]);
    assign wr_hit   = cfg_wr_en && tile_hit;
    assign rd_hit   = cfg_rd_en && tile_hit;
    assign wr_op    = dma_op_t'(cfg_wr_data[1:0]);

    // Launch only from idle, and not on top of a pending start
    assign launch = wr_hit && (reg_sel == REG_CTRL) && !dma_busy && !dma_start
                    && ((wr_op == OP_STORE) || (wr_op == OP_LOAD));

    // Store or load region onto the counter
    assign start_addr = (dma_op == OP_LOAD) ? ld_addr : st_addr;
    assign num_words  = (dma_op == OP_LOAD) ? ld_num : st_num;

    always_comb begin
        case (reg_sel)
            REG_ST_ADDR: rd_mux = {{PAD{1'b0}}, st_addr};
            REG_ST_NUM:  rd_mux = {{PAD{1'b0}}, st_num};
            REG_LD_ADDR: rd_mux = {{PAD{1'b0}}, ld_addr};
            REG_LD_NUM:  rd_mux = {{PAD{1'b0}}, ld_num};
            REG_CTRL:    rd_mux = {{(`GLB_DATA_WIDTH-2){1'b0}}, dma_op};
            // Busy in bit 0, opcode above
            REG_STATUS:  rd_mux = {{(`GLB_DATA_WIDTH-3){1'b0}}, dma_op, dma_busy};
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            st_addr      <= '0;
            st_num       <= '0;
            ld_addr      <= '0;
            ld_num       <= '0;
            dma_op       <= OP_NONE;
            dma_start    <= 1'b0;
            cfg_rd_valid <= 1'b0;
            cfg_rd_data  <= '0;
        end else if (clk_en) begin
            dma_start    <= launch;
            cfg_rd_valid <= rd_hit;
            if (launch) begin
                dma_op <= wr_op;
            end
            if (wr_hit) begin
                case (reg_sel)
                    REG_ST_ADDR: st_addr <= cfg_wr_data[`GLB_ADDR_WIDTH-1:0];
                    REG_ST_NUM:  st_num  <= cfg_wr_data[`GLB_ADDR_WIDTH-1:0];
                    REG_LD_ADDR: ld_addr <= cfg_wr_data[`GLB_ADDR_WIDTH-1:0];
                    REG_LD_NUM:  ld_num  <= cfg_wr_data[`GLB_ADDR_WIDTH-1:0];
                    default: ;
                endcase
            end
            if (rd_hit) begin
                cfg_rd_data <= rd_mux;
            end
        end
    end

    // Start pulse never lands on a running transfer
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (reset) !(dma_start && dma_busy));

endmodule

// File: logic/glb_dma_ctrl.sv
// DMA sequencer for the store and load streams
// Drives the bank DMA port through the address counter
`include "glb_cfg.svh"

module glb_dma_ctrl import glb_pkg::*; (
    input  logic                        clk,
    input  logic                        clk_en,
    input  logic                        reset,
    input  logic                        dma_start,
    input  dma_op_t                     dma_op,
    input  logic [`GLB_ADDR_WIDTH-1:0]  start_addr,
    input  logic [`GLB_ADDR_WIDTH-1:0]  num_words,
    input  logic [`GLB_DATA_WIDTH-1:0]  stream_data_f2g,
    input  logic                        stream_data_valid_f2g,
    input  logic [`GLB_DATA_WIDTH-1:0]  dma_rd_data,
    output logic                        dma_busy,
    output logic                        dma_wr_en,
    output logic                        dma_rd_en,
    output logic [`GLB_ADDR_WIDTH-1:0]  dma_addr,
    output logic [`GLB_DATA_WIDTH-1:0]  dma_wr_data,
    output logic [`GLB_DATA_WIDTH-1:0]  stream_data_g2f,
    output logic                        stream_data_valid_g2f,
    output logic                        store_done,
    output logic                        load_done
);

    dma_state_t state;
    dma_state_t state_nxt;
    logic       is_load;
    logic       cnt_load;
    logic       cnt_step;
    logic       cnt_last;

    assign cnt_load = (state == IDLE) && dma_start;
    // Store steps per valid word, load steps every cycle
    assign cnt_step = dma_wr_en || dma_rd_en;

    glb_addr_counter u_addr_counter (
        .clk        (clk),
        .clk_en     (clk_en),
        .reset      (reset),
        .load       (cnt_load),
        .step       (cnt_step),
        .start_addr (start_addr),
        .num_words  (num_words),
        .addr       (dma_addr),
        .last       (cnt_last)
    );

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (dma_start) state_nxt = (dma_op == OP_LOAD) ? LOAD : STORE;
            STORE:   if (stream_data_valid_f2g && cnt_last) state_nxt = DONE;
            LOAD:    if (cnt_last) state_nxt = DRAIN;
            // Final read data shows on g2f here
            DRAIN:   state_nxt = DONE;
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state                 <= IDLE;
            is_load               <= 1'b0;
            stream_data_valid_g2f <= 1'b0;
        end else if (clk_en) begin
            state <= state_nxt;
            if (cnt_load) begin
                is_load <= (dma_op == OP_LOAD);
            end
            // Bank read returns one cycle after the address
            stream_data_valid_g2f <= dma_rd_en;
        end
    end

    assign dma_busy        = (state != IDLE);
    assign dma_wr_en       = (state == STORE) && stream_data_valid_f2g;
    assign dma_rd_en       = (state == LOAD);
    assign dma_wr_data     = stream_data_f2g;
    assign stream_data_g2f = dma_rd_data;
    // Single done pulse from DONE, by direction
    assign store_done      = (state == DONE) && !is_load;
    assign load_done       = (state == DONE) && is_load;

    // A launch always carries a real opcode
    a_start_op_valid: assert property (
        @(posedge clk) disable iff (reset)
        dma_start |-> (dma_op == OP_STORE) || (dma_op == OP_LOAD));

endmodule

// File: logic/glb_bank.sv
// Dual-port word memory for the tile
// Processor port and DMA port with registered reads
`include "glb_cfg.svh"

module glb_bank (
    input  logic                        clk,
    input  logic                        clk_en,
    input  logic                        reset,
    input  logic                        proc_wr_en,
    input  logic                        proc_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]  proc_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]  proc_wr_data,
    input  logic                        dma_wr_en,
    input  logic                        dma_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]  dma_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]  dma_wr_data,
    output logic [`GLB_DATA_WIDTH-1:0]  proc_rd_data,
    output logic                        proc_rd_valid,
    output logic [`GLB_DATA_WIDTH-1:0]  dma_rd_data
);

    localparam int DEPTH = 1 << `GLB_ADDR_WIDTH;

    logic [`GLB_DATA_WIDTH-1:0] mem [DEPTH];

    // Writes and reads share one enabled edge
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (proc_wr_en) begin
                mem[proc_addr] <= proc_wr_data;
            end
            // Later write takes the address on a collision
            if (dma_wr_en) begin
                mem[dma_addr] <= dma_wr_data;
            end
            // Reads see the old word on a same-cycle write
            if (proc_rd_en) begin
                proc_rd_data <= mem[proc_addr];
            end
            if (dma_rd_en) begin
                dma_rd_data <= mem[dma_addr];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            proc_rd_valid <= 1'b0;
        end else if (clk_en) begin
            proc_rd_valid <= proc_rd_en;
        end
    end

endmodule

// File: logic/glb_tile.sv
// Global buffer tile top level
// Config registers, DMA controller, memory bank
// Registered interrupt chain from west to east
`include "glb_cfg.svh"

module glb_tile import glb_pkg::*; (
    input  logic                            clk,
    input  logic                            clk_en,
    input  logic                            reset,
    input  logic [`GLB_TILE_ID_WIDTH-1:0]   glb_tile_id,

    // Config bus
    input  logic                            cfg_wr_en,
    input  logic                            cfg_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]      cfg_wr_data,
    output logic [`GLB_DATA_WIDTH-1:0]      cfg_rd_data,
    output logic                            cfg_rd_valid,

    // Local processor port
    input  logic                            proc_wr_en,
    input  logic                            proc_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]      proc_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]      proc_wr_data,
    output logic [`GLB_DATA_WIDTH-1:0]      proc_rd_data,
    output logic                            proc_rd_valid,

    // Fabric streams
    input  logic [`GLB_DATA_WIDTH-1:0]      stream_data_f2g,
    input  logic                            stream_data_valid_f2g,
    output logic [`GLB_DATA_WIDTH-1:0]      stream_data_g2f,
    output logic                            stream_data_valid_g2f,

    // Interrupt chain
    input  logic [2*`GLB_NUM_TILES-1:0]     interrupt_pulse_wsti,
    output logic [2*`GLB_NUM_TILES-1:0]     interrupt_pulse_esto
);

    logic [`GLB_ADDR_WIDTH-1:0]     start_addr;
    logic [`GLB_ADDR_WIDTH-1:0]     num_words;
    logic                           dma_start;
    dma_op_t                        dma_op;
    logic                           dma_busy;
    logic                           dma_wr_en;
    logic                           dma_rd_en;
    logic [`GLB_ADDR_WIDTH-1:0]     dma_addr;
    logic [`GLB_DATA_WIDTH-1:0]     dma_wr_data;
    logic [`GLB_DATA_WIDTH-1:0]     dma_rd_data;
    logic                           store_done;
    logic                           load_done;
    logic [2*`GLB_NUM_TILES-1:0]    interrupt_word;

    // Port names line up across the blocks
    glb_cfg_regs glb_cfg_regs (.*);

    glb_dma_ctrl glb_dma_ctrl (.*);

    glb_bank glb_bank (.*);

    // Own two bits replaced by this tile's done pulses
    always_comb begin
        interrupt_word                    = interrupt_pulse_wsti;
        interrupt_word[2*glb_tile_id]     = store_done;
        interrupt_word[2*glb_tile_id + 1] = load_done;
    end

    // One enabled cycle through each tile
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            interrupt_pulse_esto <= '0;
        end else if (clk_en) begin
            interrupt_pulse_esto <= interrupt_word;
        end
    end

endmodule

// File: verif/glb_clk_gen.sv
// Testbench clock and reset source
// 100 ns clock, reset held for the first 3 cycles
module glb_clk_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        // Three rising edges under reset
        repeat (3) @(posedge clk);
        #5 reset = 1'b0;
    end

    always #50 clk = ~clk;

endmodule

// File: verif/glb_checker.sv
// Reference model and comparator for the tile
// Model bank, config registers and DMA sequence, checked at negedge
`include "glb_cfg.svh"

module glb_checker import glb_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            clk_en,
    input  logic [`GLB_TILE_ID_WIDTH-1:0]   glb_tile_id,
    input  logic                            cfg_wr_en,
    input  logic                            cfg_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0]  cfg_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]      cfg_wr_data,
    input  logic [`GLB_DATA_WIDTH-1:0]      cfg_rd_data,
    input  logic                            cfg_rd_valid,
    input  logic                            proc_wr_en,
    input  logic                            proc_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]      proc_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]      proc_wr_data,
    input  logic [`GLB_DATA_WIDTH-1:0]      proc_rd_data,
    input  logic                            proc_rd_valid,
    input  logic [`GLB_DATA_WIDTH-1:0]      stream_data_f2g,
    input  logic                            stream_data_valid_f2g,
    input  logic [`GLB_DATA_WIDTH-1:0]      stream_data_g2f,
    input  logic                            stream_data_valid_g2f,
    input  logic [2*`GLB_NUM_TILES-1:0]     interrupt_pulse_wsti,
    input  logic [2*`GLB_NUM_TILES-1:0]     interrupt_pulse_esto,
    output int                              error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // Model phases: 0 idle, 1 store, 2 load, 3 drain, 4 done
    logic [`GLB_DATA_WIDTH-1:0]     mem [256];
    logic [7:0]                     st_addr, st_num, ld_addr, ld_num;
    logic [1:0]                     op;
    logic [7:0]                     addr;
    bit                             launch_pend;
    bit                             is_load;
    int                             phase;
    int                             remain;
    int                             words_want;
    int                             g2f_count;

    // Expected outputs after the latest enabled edge
    logic                           exp_cfg_valid, exp_proc_valid, exp_g2f_valid;
    logic [`GLB_DATA_WIDTH-1:0]     exp_cfg_data, exp_proc_data, exp_g2f_data;
    logic [2*`GLB_NUM_TILES-1:0]    exp_esto;

    initial error_count = 0;

    task automatic report(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
        error_count++;
        $display("Error: time %0d ns, %s expected %h actual %h", $time, name, exp_v, act_v);
    endtask

    function automatic logic [15:0] reg_value(input logic [2:0] sel, input logic busy);
        case (sel)
            3'd0:    return {8'h00, st_addr};
            3'd1:    return {8'h00, st_num};
            3'd2:    return {8'h00, ld_addr};
            3'd3:    return {8'h00, ld_num};
            3'd4:    return {14'h0, op};
            // Status word
            3'd5:    return {13'h0, op, busy};
            default: return 16'h0;
        endcase
    endfunction

    always @(posedge clk or posedge reset) begin : model
        logic       hit;
        logic       busy;
        logic       launch;
        logic [7:0] n;
        if (reset) begin
            {st_addr, st_num, ld_addr, ld_num} = '0;
            op = 2'd0;
            launch_pend = 0;
            phase = 0;
            g2f_count = 0;
            exp_cfg_valid = 0;
            exp_proc_valid = 0;
            exp_g2f_valid = 0;
            exp_cfg_data = '0;
            exp_esto = '0;
        end else if (clk_en) begin
            hit  = cfg_addr[4:3] == glb_tile_id;
            busy = (phase != 0);
            // Outputs from the state before this edge
            exp_cfg_valid = cfg_rd_en && hit;
            if (exp_cfg_valid) exp_cfg_data = reg_value(cfg_addr[2:0], busy);
            exp_proc_valid = proc_rd_en;
            if (proc_rd_en) exp_proc_data = mem[proc_addr];
            exp_g2f_valid = (phase == 2);
            if (phase == 2) exp_g2f_data = mem[addr];
            exp_esto = interrupt_pulse_wsti;
            exp_esto[2*glb_tile_id]     = (phase == 4) && !is_load;
            exp_esto[2*glb_tile_id + 1] = (phase == 4) && is_load;
            // Words seen on g2f for this load
            if (stream_data_valid_g2f) g2f_count++;
            if (phase == 4 && is_load) begin
                if (g2f_count != words_want) report("g2f word count", words_want, g2f_count);
                g2f_count = 0;
            end
            // Bank writes with the DMA last so it wins
            if (proc_wr_en) mem[proc_addr] = proc_wr_data;
            if (phase == 1 && stream_data_valid_f2g) mem[addr] = stream_data_f2g;
            case (phase)
                0: if (launch_pend) begin
                    is_load = (op == 2'd2);
                    addr = is_load ? ld_addr : st_addr;
                    n = is_load ? ld_num : st_num;
                    remain = (n == 0) ? 256 : n;
                    words_want = remain;
                    phase = is_load ? 2 : 1;
                end
                1: if (stream_data_valid_f2g) begin
                    addr++;
                    remain--;
                    if (remain == 0) phase = 4;
                end
                2: begin
                    addr++;
                    remain--;
                    if (remain == 0) phase = 3;
                end
                3: phase = 4;
                default: phase = 0;
            endcase
            // Launch only from idle with nothing pending
            launch = cfg_wr_en && hit && cfg_addr[2:0] == 3'd4 && !busy && !launch_pend
                     && (cfg_wr_data[1:0] == 2'd1 || cfg_wr_data[1:0] == 2'd2);
            launch_pend = launch;
            if (launch) op = cfg_wr_data[1:0];
            if (cfg_wr_en && hit) begin
                case (cfg_addr[2:0])
                    3'd0: st_addr = cfg_wr_data[7:0];
                    3'd1: st_num  = cfg_wr_data[7:0];
                    3'd2: ld_addr = cfg_wr_data[7:0];
                    3'd3: ld_num  = cfg_wr_data[7:0];
                    default: ;
                endcase
            end
        end
    end

    // Compare mid-cycle once outputs settle, including cycles where clk_en holds them
    always @(negedge clk) begin
        if (!reset) begin
            if (cfg_rd_valid !== exp_cfg_valid) report("cfg_rd_valid", exp_cfg_valid, cfg_rd_valid);
            if (exp_cfg_valid && cfg_rd_data !== exp_cfg_data)
                report("cfg_rd_data", exp_cfg_data, cfg_rd_data);
            if (proc_rd_valid !== exp_proc_valid)
                report("proc_rd_valid", exp_proc_valid, proc_rd_valid);
            if (exp_proc_valid && proc_rd_data !== exp_proc_data)
                report("proc_rd_data", exp_proc_data, proc_rd_data);
            if (stream_data_valid_g2f !== exp_g2f_valid)
                report("stream_data_valid_g2f", exp_g2f_valid, stream_data_valid_g2f);
            if (exp_g2f_valid && stream_data_g2f !== exp_g2f_data)
                report("stream_data_g2f", exp_g2f_data, stream_data_g2f);
            if (interrupt_pulse_esto !== exp_esto)
                report("interrupt_pulse_esto", exp_esto, interrupt_pulse_esto);
        end
    end

endmodule

// File: verif/tb_glb_tile.sv
// Testbench top for the global buffer tile
// Random config, processor and DMA traffic with a cycle limit
`include "glb_cfg.svh"

module tb_glb_tile import glb_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    // Rough cycle cost of each test
    localparam int CFG_CYCLES  = 60;
    localparam int FILL_CYCLES = 256;
    localparam int PROC_CYCLES = 150;
    localparam int DMA_CYCLES  = 6 * 260;
    localparam int LIMIT = (CFG_CYCLES + FILL_CYCLES + PROC_CYCLES + DMA_CYCLES) * 3 / 2;

    logic clk, reset, clk_en;
    logic [1:0] glb_tile_id;
    logic cfg_wr_en, cfg_rd_en, cfg_rd_valid;
    logic [4:0] cfg_addr;
    logic [15:0] cfg_wr_data, cfg_rd_data;
    logic proc_wr_en, proc_rd_en, proc_rd_valid;
    logic [7:0] proc_addr;
    logic [15:0] proc_wr_data, proc_rd_data;
    logic [15:0] stream_data_f2g, stream_data_g2f;
    logic stream_data_valid_f2g, stream_data_valid_g2f;
    logic [7:0] interrupt_pulse_wsti, interrupt_pulse_esto;
    int error_count;
    int cycles;
    integer seed = 29733;

    glb_clk_gen clk_gen (.clk(clk), .reset(reset));
    glb_tile DUT (.*);
    glb_checker u_checker (.*);

    // Hold inputs until an enabled edge has taken them
    task automatic step();
        bit en;
        do begin
            en = ($random(seed) & 7) != 0;
            clk_en = en;
            interrupt_pulse_wsti = $random(seed);
            @(posedge clk);
            #5;
        end while (!en);
    endtask

    task automatic cfg_access(input bit wr, input logic [1:0] tile, input logic [2:0] sel,
                              input logic [15:0] data);
        cfg_wr_en = wr;
        cfg_rd_en = !wr;
        cfg_addr = {tile, sel};
        cfg_wr_data = data;
        step();
        cfg_wr_en = 0;
        cfg_rd_en = 0;
    endtask

    task automatic proc_access(input bit wr, input logic [7:0] a, input logic [15:0] data);
        proc_wr_en = wr;
        proc_rd_en = !wr;
        proc_addr = a;
        proc_wr_data = data;
        step();
        proc_wr_en = 0;
        proc_rd_en = 0;
    endtask

    task automatic run_store(input logic [7:0] start, input logic [7:0] len, input bit poke);
        int k;
        cfg_access(1, 2'd2, REG_ST_ADDR, start);
        cfg_access(1, 2'd2, REG_ST_NUM, len);
        cfg_access(1, 2'd2, REG_CTRL, OP_STORE);
        k = 0;
        // Stream with gaps until the store done bit comes through
        do begin
            stream_data_valid_f2g = ($random(seed) & 3) != 0;
            stream_data_f2g = $random(seed);
            if (poke && k == 4) begin
                cfg_wr_en = 1;
                cfg_addr = {2'd2, REG_CTRL};
                cfg_wr_data = OP_LOAD;
            end
            step();
            cfg_wr_en = 0;
            stream_data_valid_f2g = 0;
            k++;
        end while (!interrupt_pulse_esto[4]);
    endtask

    task automatic run_load(input logic [7:0] start, input logic [7:0] len);
        cfg_access(1, 2'd2, REG_LD_ADDR, start);
        cfg_access(1, 2'd2, REG_LD_NUM, len);
        cfg_access(1, 2'd2, REG_CTRL, OP_LOAD);
        do step(); while (!interrupt_pulse_esto[5]);
    endtask

    initial begin
        logic [7:0] start;
        logic [7:0] len;
        {clk_en, cfg_wr_en, cfg_rd_en, proc_wr_en, proc_rd_en, stream_data_valid_f2g} = '0;
        glb_tile_id = 2'd2;
        cfg_addr = '0;
        cfg_wr_data = '0;
        proc_addr = '0;
        proc_wr_data = '0;
        stream_data_f2g = '0;
        interrupt_pulse_wsti = '0;
        @(negedge reset);
        @(posedge clk);
        #5;
        // Own registers, then other tile selects, then read back
        for (int r = 0; r < 4; r++) cfg_access(1, 2'd2, r, $random(seed));
        for (int r = 0; r < 6; r++) cfg_access(0, 2'd2, r, 0);
        for (int t = 0; t < 4; t++) begin
            if (t != 2) begin
                cfg_access(1, t, $random(seed) % 4, $random(seed));
                cfg_access(0, t, $random(seed) % 6, 0);
            end
        end
        for (int r = 0; r < 4; r++) cfg_access(0, 2'd2, r, 0);
        // Fill pattern over the whole address
        for (int a = 0; a < 256; a++) proc_access(1, a, {a[7:0], ~a[7:0]} ^ 16'h5a00);
        for (int i = 0; i < 100; i++) proc_access($random(seed) & 1, $random(seed), $random(seed));
        for (int i = 0; i < 6; i++) begin
            start = (i == 0) ? 8'd250 : $random(seed);
            // First region runs past the top of the bank
            len = (i == 0) ? 8'd20 : (i == 2) ? 8'd30 : 8'd1 + ($unsigned($random(seed)) % 40);
            run_store(start, len, i == 2);
            // Opcode still reads as the store after a rejected launch
            cfg_access(0, 2'd2, REG_STATUS, 0);
            for (int a = 0; a < len; a++) proc_access(0, start + a, 0);
            run_load(start, len);
            cfg_access(0, 2'd2, REG_STATUS, 0);
        end
        repeat (4) step();
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("Errors: %0d", error_count);
            $display("Result: FAILED");
            $finish;
        end
    end

endmodule

// File: files.f
+incdir+include
logic/glb_pkg.sv
logic/glb_addr_counter.sv
logic/glb_cfg_regs.sv
logic/glb_dma_ctrl.sv
logic/glb_bank.sv
logic/glb_tile.sv
verif/glb_clk_gen.sv
verif/glb_checker.sv
verif/tb_glb_tile.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_glb_tile
RTL_TOP   ?= glb_tile
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
